// File: common/dcore_config.svh
`ifndef DCORE_CONFIG_SVH
`define DCORE_CONFIG_SVH

// ADC magnitude width, sign comes separately
`define NADC 8

// number of time-interleaved slices
`define NTI 8

// PRBS order, polynomial x^7+x^6+1
`define NPRBS 7

// bit counter width
`define NCNT 32

// width of the divider and averaging controls
`define NCTL 3

`endif

// File: common/dcore_pkg.sv
`include "dcore_config.svh"

package dcore_pkg;

    // unfolded code: magnitude plus sign, two's complement
    typedef logic signed [`NADC:0] adc_code_t;

    // comparator offset, same range as a code
    typedef logic signed [`NADC:0] pfd_offset_t;

    // clipping bounds for the code after offset removal
    localparam adc_code_t CODE_MAX = adc_code_t'((2 ** `NADC) - 1);
    localparam adc_code_t CODE_MIN = adc_code_t'(-(2 ** `NADC));

    // checker counter control
    typedef enum logic [1:0] {
        PRBS_CLEAR = 2'd0,
        PRBS_COUNT = 2'd1,
        PRBS_HOLD  = 2'd2
    } prbs_mode_e;

    // averaging state of one slice
    typedef enum logic {
        CAL_IDLE  = 1'b0,
        CAL_ACCUM = 1'b1
    } cal_state_e;

endpackage

// File: logic/ti_adc_retimer.sv
`timescale 1ns/10ps
`default_nettype none
`include "dcore_config.svh"

module ti_adc_retimer (
    input  wire logic             clk_adc,
    input  wire logic             rst_n_i,
    input  wire logic [`NADC-1:0] in_data_i [`NTI-1:0],
    input  wire logic [`NTI-1:0]  in_sign_i,
    output logic      [`NADC-1:0] out_data_o [`NTI-1:0],
    output logic      [`NTI-1:0]  out_sign_o
);

    // all slices land in the same register stage
    // so the rest of the core sees one parallel word per cycle
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < `NTI; k++) begin
                out_data_o[k] <= '0;
            end
            out_sign_o <= '0;
        end else begin
            for (int k = 0; k < `NTI; k++) begin
                out_data_o[k] <= in_data_i[k];
            end
            out_sign_o <= in_sign_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/avg_tick_gen.sv
`timescale 1ns/10ps
`default_nettype none
`include "dcore_config.svh"

module avg_tick_gen (
    input  wire logic             clk_adc,
    input  wire logic             rst_n_i,
    input  wire logic [`NCTL-1:0] ndiv_i,
    output logic                  tick_o
);

    // wide enough for the largest division, 2^(2^NCTL - 1)
    localparam int CNT_W = (2 ** `NCTL) - 1;

    logic [CNT_W-1:0] div_cnt;
    logic [CNT_W-1:0] div_mask;

    // low ndiv_i bits set
    assign div_mask = ~({CNT_W{1'b1}} << ndiv_i);

    // tick is registered so it stays low through reset
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt <= '0;
            tick_o  <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            // low bits about to wrap to zero
            tick_o  <= ((div_cnt & div_mask) == div_mask);
        end
    end

endmodule

`default_nettype wire

// File: adc_unfolding/adc_unfolding.sv
`timescale 1ns/10ps
`default_nettype none
`include "dcore_config.svh"

module adc_unfolding import dcore_pkg::*; (
    input  wire logic             clk_adc,
    input  wire logic             rst_n_i,
    input  wire logic             avg_tick_i,
    input  wire logic [`NADC-1:0] din_i,
    input  wire logic             sign_i,
    input  wire logic             en_pfd_cal_i,
    input  wire logic             en_ext_pfd_offset_i,
    input  wire pfd_offset_t      ext_pfd_offset_i,
    input  wire logic [`NCTL-1:0] navg_i,
    output adc_code_t             dout_o,
    output pfd_offset_t           pfd_offset_o
);

    // up to 2^7 codes summed without overflow
    localparam int NAVG_MAX = (2 ** `NCTL) - 1;
    localparam int SUM_W    = $bits(adc_code_t) + NAVG_MAX;

    cal_state_e              cal_state;
    logic signed [SUM_W-1:0] acc_sum;
    logic signed [SUM_W-1:0] acc_next;
    logic [NAVG_MAX-1:0]     tick_cnt;
    logic [NAVG_MAX-1:0]     tick_last;
    adc_code_t               raw_code;
    pfd_offset_t             cal_offset;
    pfd_offset_t             applied_offset;
    logic signed [`NADC+1:0] diff;

    // sign bit set means positive
    assign raw_code = sign_i ? adc_code_t'({1'b0, din_i}) : -adc_code_t'({1'b0, din_i});

    assign acc_next = acc_sum + raw_code;

    // 2^navg_i ticks per average
    assign tick_last = ~({NAVG_MAX{1'b1}} << navg_i);

    // averaging runs only while calibration is enabled
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cal_state  <= CAL_IDLE;
            acc_sum    <= '0;
            tick_cnt   <= '0;
            cal_offset <= '0;
        end else begin
            case (cal_state)
                CAL_IDLE: begin
                    acc_sum  <= '0;
                    tick_cnt <= '0;
                    if (en_pfd_cal_i) begin
                        cal_state <= CAL_ACCUM;
                    end
                end
                CAL_ACCUM: begin
                    if (!en_pfd_cal_i) begin
                        cal_state <= CAL_IDLE;
                    end else if (avg_tick_i) begin
                        if (tick_cnt == tick_last) begin
                            // divide by the tick count, then start over
                            cal_offset <= pfd_offset_t'(acc_next >>> navg_i);
                            acc_sum    <= '0;
                            tick_cnt   <= '0;
                        end else begin
                            acc_sum  <= acc_next;
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    cal_state <= CAL_IDLE;
                end
            endcase
        end
    end

    assign applied_offset = en_ext_pfd_offset_i ? ext_pfd_offset_i : cal_offset;
    assign pfd_offset_o   = applied_offset;

    // one extra bit so the clip can see the overflow
    assign diff = raw_code - applied_offset;

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dout_o <= '0;
        end else if (diff > CODE_MAX) begin
            dout_o <= CODE_MAX;
        end else if (diff < CODE_MIN) begin
            dout_o <= CODE_MIN;
        end else begin
            dout_o <= adc_code_t'(diff);
        end
    end

endmodule

`default_nettype wire

// File: logic/comb_comp.sv
`timescale 1ns/10ps
`default_nettype none
`include "dcore_config.svh"

module comb_comp import dcore_pkg::*; (
    input  wire logic        clk_adc,
    input  wire logic        rst_n_i,
    input  wire adc_code_t   codes_i [`NTI-1:0],
    input  wire adc_code_t   thresh_i,
    output logic [`NTI-1:0]  bit_o
);

    // signed compare, a code equal to the threshold gives 0
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_o <= '0;
        end else begin
            for (int k = 0; k < `NTI; k++) begin
                bit_o[k] <= (codes_i[k] > thresh_i);
            end
        end
    end

endmodule

`default_nettype wire

// File: prbs_checker/prbs_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "dcore_config.svh"

module prbs_checker import dcore_pkg::*; (
    input  wire logic             clk_adc,
    input  wire logic             rst_n_i,
    input  wire prbs_mode_e       mode_i,
    input  wire logic [`NTI-1:0]  rx_bits_i,
    output logic      [`NCNT-1:0] correct_bits_o,
    output logic      [`NCNT-1:0] total_bits_o
);

    localparam int NEXT     = `NPRBS + `NTI;
    localparam int NMATCH_W = $clog2(`NTI + 1);

    // hist[0] is the oldest bit kept
    logic [`NPRBS-1:0]   hist;
    logic [NEXT-1:0]     ext_bits;
    logic [`NTI-1:0]     match;
    logic [NMATCH_W-1:0] n_match;

    // history below, new word above, bit 0 of the word earliest
    assign ext_bits = {rx_bits_i, hist};

    // each position is predicted from received bits only,
    // so a single flipped bit disturbs at most three checks
    always_comb begin
        n_match = '0;
        for (int k = 0; k < `NTI; k++) begin
            // taps at n-7 and n-6
            match[k] = (rx_bits_i[k] == (ext_bits[k] ^ ext_bits[k + 1]));
            n_match  = n_match + NMATCH_W'(match[k]);
        end
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hist <= '0;
        end else begin
            hist <= ext_bits[NEXT-1 -: `NPRBS];
        end
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            correct_bits_o <= '0;
            total_bits_o   <= '0;
        end else begin
            case (mode_i)
                PRBS_CLEAR: begin
                    correct_bits_o <= '0;
                    total_bits_o   <= '0;
                end
                PRBS_COUNT: begin
                    correct_bits_o <= correct_bits_o + `NCNT'(n_match);
                    total_bits_o   <= total_bits_o + `NCNT'(`NTI);
                end
                default: begin
                    // hold
                    correct_bits_o <= correct_bits_o;
                    total_bits_o   <= total_bits_o;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/digital_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "dcore_config.svh"

module digital_core import dcore_pkg::*; (
    input  wire logic             clk_adc,
    input  wire logic             rst_n_i,
    input  wire logic [`NADC-1:0] adcout_i [`NTI-1:0],
    input  wire logic [`NTI-1:0]  adcout_sign_i,
    input  wire logic             en_pfd_cal_i,
    input  wire logic             en_ext_pfd_offset_i,
    input  wire pfd_offset_t      ext_pfd_offset_i [`NTI-1:0],
    input  wire logic [`NCTL-1:0] ndiv_avg_i,
    input  wire logic [`NCTL-1:0] navg_i,
    input  wire adc_code_t        thresh_i,
    input  wire prbs_mode_e       prbs_mode_i,
    output wire adc_code_t        adc_unfolded_o [`NTI-1:0],
    output wire pfd_offset_t      pfd_offset_o [`NTI-1:0],
    output wire logic [`NCNT-1:0] correct_bits_o,
    output wire logic [`NCNT-1:0] total_bits_o
);

    wire logic [`NADC-1:0] adcout_retimed [`NTI-1:0];
    wire logic [`NTI-1:0]  adcout_sign_retimed;
    wire logic             avg_tick;
    wire logic [`NTI-1:0]  rx_bits;

    ti_adc_retimer retimer_i (
        .clk_adc    (clk_adc),
        .rst_n_i    (rst_n_i),
        .in_data_i  (adcout_i),
        .in_sign_i  (adcout_sign_i),
        .out_data_o (adcout_retimed),
        .out_sign_o (adcout_sign_retimed)
    );

    // one-cycle averaging tick shared by all slices
    avg_tick_gen avg_tick_i (
        .clk_adc (clk_adc),
        .rst_n_i (rst_n_i),
        .ndiv_i  (ndiv_avg_i),
        .tick_o  (avg_tick)
    );

    genvar k;
    generate
        for (k = 0; k < `NTI; k++) begin : g_slice
            adc_unfolding unfold_i (
                .clk_adc             (clk_adc),
                .rst_n_i             (rst_n_i),
                .avg_tick_i          (avg_tick),
                .din_i               (adcout_retimed[k]),
                .sign_i              (adcout_sign_retimed[k]),
                .en_pfd_cal_i        (en_pfd_cal_i),
                .en_ext_pfd_offset_i (en_ext_pfd_offset_i),
                .ext_pfd_offset_i    (ext_pfd_offset_i[k]),
                .navg_i              (navg_i),
                .dout_o              (adc_unfolded_o[k]),
                .pfd_offset_o        (pfd_offset_o[k])
            );
        end
    endgenerate

    // bit decision straight from the unfolded codes
    comb_comp comp_i (
        .clk_adc  (clk_adc),
        .rst_n_i  (rst_n_i),
        .codes_i  (adc_unfolded_o),
        .thresh_i (thresh_i),
        .bit_o    (rx_bits)
    );

    prbs_checker prbs_checker_i (
        .clk_adc        (clk_adc),
        .rst_n_i        (rst_n_i),
        .mode_i         (prbs_mode_i),
        .rx_bits_i      (rx_bits),
        .correct_bits_o (correct_bits_o),
        .total_bits_o   (total_bits_o)
    );

endmodule

`default_nettype wire

// File: dv/tb_digital_core.sv
`timescale 1ns/10ps
`include "dcore_config.svh"

module tb_digital_core import dcore_pkg::*; ();

    logic             clk;
    logic             rst_n;
    logic [`NADC-1:0] adc_data [`NTI-1:0];
    logic [`NTI-1:0]  adc_sign;
    logic             en_pfd_cal;
    logic             en_ext_offset;
    pfd_offset_t      ext_offset [`NTI-1:0];
    logic [`NCTL-1:0] ndiv_avg;
    logic [`NCTL-1:0] navg;
    adc_code_t        thresh;
    prbs_mode_e       prbs_mode;
    adc_code_t        unfolded [`NTI-1:0];
    pfd_offset_t      pfd_offset [`NTI-1:0];
    logic [`NCNT-1:0] correct_bits;
    logic [`NCNT-1:0] total_bits;

    // reference model with one entry per pipeline register
    int                ret_code [`NTI];
    int                mdl_code [`NTI];
    int                mdl_cal [`NTI];
    logic [`NTI-1:0]   mdl_bits;
    logic [`NPRBS-1:0] mdl_hist;
    logic [`NCNT-1:0]  mdl_correct;
    logic [`NCNT-1:0]  mdl_total;
    bit                compare_en;

    // PRBS7 source state with the oldest bit at 0
    logic [`NPRBS-1:0] gen_hist;
    int                cal_value [`NTI];
    int                n_flips;
    int                code_errs;
    int                offset_errs;
    int                count_errs;
    int                other_errs;

    digital_core dut0 (
        .clk_adc             (clk),
        .rst_n_i             (rst_n),
        .adcout_i            (adc_data),
        .adcout_sign_i       (adc_sign),
        .en_pfd_cal_i        (en_pfd_cal),
        .en_ext_pfd_offset_i (en_ext_offset),
        .ext_pfd_offset_i    (ext_offset),
        .ndiv_avg_i          (ndiv_avg),
        .navg_i              (navg),
        .thresh_i            (thresh),
        .prbs_mode_i         (prbs_mode),
        .adc_unfolded_o      (unfolded),
        .pfd_offset_o        (pfd_offset),
        .correct_bits_o      (correct_bits),
        .total_bits_o        (total_bits)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic int clip_code(input int v);
        int hi;
        int lo;
        hi = (1 << `NADC) - 1;
        lo = -(1 << `NADC);
        if (v > hi) begin
            return hi;
        end else if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    function automatic int applied_offset(input int k);
        if (en_ext_offset) begin
            return int'(ext_offset[k]);
        end
        return mdl_cal[k];
    endfunction

    // x^7+x^6+1 gives b[n] = b[n-7] ^ b[n-6]
    function automatic logic next_prbs_bit();
        logic b;
        b = gen_hist[0] ^ gen_hist[1];
        gen_hist = {b, gen_hist[`NPRBS-1:1]};
        return b;
    endfunction

    // one clock edge with later stages updated first
    task automatic advance_model();
        int   n_ok;
        logic pred;
        n_ok = 0;
        for (int k = 0; k < `NTI; k++) begin
            // prediction always from received bits
            pred = mdl_hist[0] ^ mdl_hist[1];
            if (mdl_bits[k] == pred) begin
                n_ok++;
            end
            mdl_hist = {mdl_bits[k], mdl_hist[`NPRBS-1:1]};
        end
        case (prbs_mode)
            PRBS_CLEAR: begin
                mdl_correct = '0;
                mdl_total   = '0;
            end
            PRBS_COUNT: begin
                mdl_correct = mdl_correct + `NCNT'(n_ok);
                mdl_total   = mdl_total + `NCNT'(`NTI);
            end
            default: begin
            end
        endcase
        for (int k = 0; k < `NTI; k++) begin
            mdl_bits[k] = (mdl_code[k] > int'(thresh));
            mdl_code[k] = clip_code(ret_code[k] - applied_offset(k));
            ret_code[k] = adc_sign[k] ? int'(adc_data[k]) : -int'(adc_data[k]);
        end
    endtask

    task automatic check_code(input adc_code_t got, input adc_code_t exp, input string what);
        if (got !== exp) begin
            code_errs++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_offset(input pfd_offset_t got, input pfd_offset_t exp,
                                input string what);
        if (got !== exp) begin
            offset_errs++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input logic [`NCNT-1:0] got, input logic [`NCNT-1:0] exp,
                               input string what);
        if (got !== exp) begin
            count_errs++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_outputs();
        if (compare_en) begin
            for (int k = 0; k < `NTI; k++) begin
                check_code(unfolded[k], adc_code_t'(mdl_code[k]),
                           $sformatf("code of slice %0d", k));
                check_offset(pfd_offset[k], pfd_offset_t'(applied_offset(k)),
                             $sformatf("offset of slice %0d", k));
            end
            check_count(correct_bits, mdl_correct, "correct bit count");
            check_count(total_bits, mdl_total, "total bit count");
        end
    endtask

    // outputs are sampled on the falling edge before new inputs go out
    task automatic next_cycle();
        @(negedge clk);
        advance_model();
        compare_outputs();
    endtask

    task automatic drive_random_word();
        for (int k = 0; k < `NTI; k++) begin
            adc_data[k] = `NADC'($urandom);
            adc_sign[k] = 1'($urandom);
        end
        // threshold changes every word as well
        thresh = adc_code_t'($urandom);
    endtask

    // flip_odds of 0 sends a clean stream
    task automatic drive_prbs_word(input int flip_odds);
        logic b;
        for (int k = 0; k < `NTI; k++) begin
            b = next_prbs_bit();
            if (flip_odds > 0 && ($urandom % flip_odds) == 0) begin
                b = ~b;
                n_flips++;
            end
            adc_sign[k] = b;
            adc_data[k] = b ? `NADC'($urandom_range((1 << `NADC) - 1, 1)) : `NADC'($urandom);
        end
    endtask

    initial begin
        int               waited;
        bit               changed;
        int               mag;
        pfd_offset_t      start_offset [`NTI];
        logic [`NCNT-1:0] held_correct;
        logic [`NCNT-1:0] held_total;
        void'($urandom(32'h8a689921));
        code_errs   = 0;
        offset_errs = 0;
        count_errs  = 0;
        other_errs  = 0;
        n_flips     = 0;
        rst_n       = 1'b0;
        adc_sign    = '0;
        for (int k = 0; k < `NTI; k++) begin
            adc_data[k]   = '0;
            ext_offset[k] = '0;
            ret_code[k]   = 0;
            mdl_code[k]   = 0;
            mdl_cal[k]    = 0;
        end
        en_pfd_cal    = 1'b0;
        en_ext_offset = 1'b0;
        ndiv_avg      = `NCTL'(2);
        navg          = `NCTL'(3);
        thresh        = '0;
        prbs_mode     = PRBS_CLEAR;
        mdl_bits      = '0;
        mdl_hist      = '0;
        mdl_correct   = '0;
        mdl_total     = '0;
        compare_en    = 1'b1;
        gen_hist      = '1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // random codes against random external offsets
        en_ext_offset = 1'b1;
        prbs_mode     = PRBS_COUNT;
        for (int k = 0; k < `NTI; k++) begin
            ext_offset[k] = pfd_offset_t'($urandom);
        end
        for (int i = 0; i < 200; i++) begin
            next_cycle();
            drive_random_word();
        end

        // full-scale codes with offsets of the opposite sign
        for (int blk = 0; blk < 4; blk++) begin
            for (int k = 0; k < `NTI; k++) begin
                adc_sign[k] = 1'($urandom);
                adc_data[k] = '1;
                if (adc_sign[k]) begin
                    ext_offset[k] = pfd_offset_t'(-int'($urandom_range(1 << `NADC, 1)));
                end else begin
                    ext_offset[k] = pfd_offset_t'($urandom_range((1 << `NADC) - 1, 1));
                end
            end
            repeat (25) next_cycle();
            for (int k = 0; k < `NTI; k++) begin
                check_code(unfolded[k], adc_sign[k] ? adc_code_t'((1 << `NADC) - 1)
                                                    : adc_code_t'(-(1 << `NADC)),
                           $sformatf("clipped code of slice %0d", k));
            end
        end

        // calibration on a constant code per slice
        compare_en    = 1'b0;
        prbs_mode     = PRBS_CLEAR;
        en_ext_offset = 1'b0;
        for (int k = 0; k < `NTI; k++) begin
            mag          = int'($urandom_range((1 << `NADC) - 1, (k == 0) ? 1 : 0));
            adc_sign[k]  = 1'($urandom);
            adc_data[k]  = `NADC'(mag);
            cal_value[k] = adc_sign[k] ? mag : -mag;
        end
        repeat (3) next_cycle();
        en_pfd_cal = 1'b1;
        next_cycle();
        for (int k = 0; k < `NTI; k++) begin
            start_offset[k] = pfd_offset[k];
        end
        waited  = 0;
        changed = 1'b0;
        while (!changed && waited < 1000) begin
            next_cycle();
            waited++;
            for (int k = 0; k < `NTI; k++) begin
                if (pfd_offset[k] !== start_offset[k]) begin
                    changed = 1'b1;
                end
            end
        end
        if (!changed) begin
            other_errs++;
            $display("timeout: calibrated offsets did not change within %0d cycles", waited);
        end else begin
            for (int k = 0; k < `NTI; k++) begin
                check_offset(pfd_offset[k], pfd_offset_t'(cal_value[k]),
                             $sformatf("calibrated offset of slice %0d", k));
            end
        end
        en_pfd_cal = 1'b0;
        for (int k = 0; k < `NTI; k++) begin
            mdl_cal[k] = cal_value[k];
        end
        repeat (4) next_cycle();
        compare_en = 1'b1;
        for (int i = 0; i < 10; i++) begin
            next_cycle();
            for (int k = 0; k < `NTI; k++) begin
                check_code(unfolded[k], '0, $sformatf("calibrated code of slice %0d", k));
            end
        end

        // clean PRBS7 stream while the history fills with counters cleared
        en_ext_offset = 1'b1;
        thresh        = '0;
        for (int k = 0; k < `NTI; k++) begin
            ext_offset[k] = '0;
        end
        for (int i = 0; i < 10; i++) begin
            next_cycle();
            drive_prbs_word(0);
        end
        prbs_mode = PRBS_COUNT;
        for (int i = 0; i < 300; i++) begin
            next_cycle();
            check_count(total_bits, `NCNT'(`NTI * (i + 1)), "total bit step");
            check_count(correct_bits, `NCNT'(`NTI * (i + 1)), "error-free correct count");
            drive_prbs_word(0);
        end

        // flipped bits followed by hold and clear
        n_flips = 0;
        for (int i = 0; i < 300; i++) begin
            next_cycle();
            drive_prbs_word(16);
        end
        repeat (4) begin
            next_cycle();
            drive_prbs_word(0);
        end
        if (n_flips == 0 || correct_bits == mdl_total) begin
            other_errs++;
            $display("no bit errors were counted after %0d flipped bits", n_flips);
        end
        prbs_mode    = PRBS_HOLD;
        held_correct = mdl_correct;
        held_total   = mdl_total;
        for (int i = 0; i < 50; i++) begin
            next_cycle();
            check_count(correct_bits, held_correct, "held correct count");
            check_count(total_bits, held_total, "held total count");
            drive_prbs_word(16);
        end
        prbs_mode = PRBS_CLEAR;
        for (int i = 0; i < 5; i++) begin
            next_cycle();
            check_count(correct_bits, '0, "cleared correct count");
            check_count(total_bits, '0, "cleared total count");
            drive_prbs_word(0);
        end

        $display("errors: code %0d, offset %0d, count %0d, other %0d",
                 code_errs, offset_errs, count_errs, other_errs);
        if (code_errs + offset_errs + count_errs + other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+common
common/dcore_pkg.sv
logic/ti_adc_retimer.sv
logic/avg_tick_gen.sv
adc_unfolding/adc_unfolding.sv
logic/comb_comp.sv
prbs_checker/prbs_checker.sv
logic/digital_core.sv
dv/tb_digital_core.sv

// File: Makefile
# Verilator flow for the digital core testbench

VERILATOR ?= verilator
TOP       ?= tb_digital_core
FLIST     ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# output is kept in a shell variable and searched for the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
